// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module id_stage_tb

run: build
	@out="$$(./obj_dir/Vid_stage_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module id_stage_tb

clean:
	rm -rf obj_dir

// File: design/id_pkg.sv
package id_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	//////////////////////////////
	// instruction fields
	//////////////////////////////
	// primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0A,
		OP_SLTIU   = 6'h0B,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_PREF    = 6'h33
	} opcode_e;

	// SPECIAL function codes, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL   = 6'h00,
		FN_SRL   = 6'h02,
		FN_SRA   = 6'h03,
		FN_SLLV  = 6'h04,
		FN_SRLV  = 6'h06,
		FN_SRAV  = 6'h07,
		FN_MOVZ  = 6'h0A,
		FN_MOVN  = 6'h0B,
		FN_SYNC  = 6'h0F,
		FN_MFHI  = 6'h10,
		FN_MTHI  = 6'h11,
		FN_MFLO  = 6'h12,
		FN_MTLO  = 6'h13,
		FN_MULT  = 6'h18,
		FN_MULTU = 6'h19,
		FN_ADD   = 6'h20,
		FN_ADDU  = 6'h21,
		FN_SUB   = 6'h22,
		FN_SUBU  = 6'h23,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_XOR   = 6'h26,
		FN_NOR   = 6'h27,
		FN_SLT   = 6'h2A,
		FN_SLTU  = 6'h2B
	} funct_e;

	//////////////////////////////
	// execute control
	//////////////////////////////
	typedef enum logic [2:0] {
		SEL_NOP   = 3'd0,
		SEL_LOGIC = 3'd1,
		SEL_SHIFT = 3'd2,
		SEL_MOVE  = 3'd3,
		SEL_ARITH = 3'd4
	} alusel_e;

	// function code for SPECIAL, opcode for I-type
	typedef enum logic [7:0] {
		ALUOP_SLL   = 8'h00,
		ALUOP_SRL   = 8'h02,
		ALUOP_SRA   = 8'h03,
		ALUOP_SLLV  = 8'h04,
		ALUOP_SRLV  = 8'h06,
		ALUOP_SRAV  = 8'h07,
		ALUOP_ADDI  = 8'h08,
		ALUOP_ADDIU = 8'h09,
		ALUOP_MOVZ  = 8'h0A,
		ALUOP_MOVN  = 8'h0B,
		ALUOP_ANDI  = 8'h0C,
		ALUOP_ORI   = 8'h0D,
		ALUOP_XORI  = 8'h0E,
		ALUOP_LUI   = 8'h0F,
		ALUOP_MFHI  = 8'h10,
		ALUOP_MTHI  = 8'h11,
		ALUOP_MFLO  = 8'h12,
		ALUOP_MTLO  = 8'h13,
		ALUOP_MULT  = 8'h18,
		ALUOP_MULTU = 8'h19,
		ALUOP_ADD   = 8'h20,
		ALUOP_ADDU  = 8'h21,
		ALUOP_SUB   = 8'h22,
		ALUOP_SUBU  = 8'h23,
		ALUOP_AND   = 8'h24,
		ALUOP_OR    = 8'h25,
		ALUOP_XOR   = 8'h26,
		ALUOP_NOR   = 8'h27,
		ALUOP_SLT   = 8'h2A,
		ALUOP_SLTU  = 8'h2B,
		ALUOP_PREF  = 8'h33
	} aluop_e;

	// codes that overlap, execute tells them apart by alusel
	localparam aluop_e ALUOP_NOP   = ALUOP_SLL;
	localparam aluop_e ALUOP_SLTI  = ALUOP_MOVZ;
	localparam aluop_e ALUOP_SLTIU = ALUOP_MOVN;

	typedef struct packed {
		alusel_e               alusel;
		aluop_e                aluop;
		logic                  wreg;
		logic [REG_ADDR_W-1:0] waddr;
	} ex_ctrl_t;

	// one per register file read port
	typedef struct packed {
		logic                  rd;
		logic [REG_ADDR_W-1:0] addr;
	} rf_req_t;

	// result on its way back from a later stage
	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] waddr;
		logic [DATA_W-1:0]     wdata;
	} fwd_t;

endpackage

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage
	import id_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,

	// fetch side
	input  logic [DATA_W-1:0] pc_i,
	input  logic [DATA_W-1:0] inst_i,

	// register file
	input  logic [DATA_W-1:0] rf1_data_i,
	input  logic [DATA_W-1:0] rf2_data_i,
	output rf_req_t           rf1_req_o,
	output rf_req_t           rf2_req_o,

	// bypass from later stages
	input  fwd_t              ex_fwd_i,
	input  fwd_t              mem_fwd_i,

	// to execute
	output ex_ctrl_t          ex_ctrl_o,
	output logic [DATA_W-1:0] op1_o,
	output logic [DATA_W-1:0] op2_o
);

	logic [DATA_W-1:0] imm;

	//////////////////////////////
	// registered decode
	//////////////////////////////
	instr_decoder u_decoder (
		.clk       (clk),
		.reset_n   (reset_n),
		.pc_i      (pc_i),
		.inst_i    (inst_i),
		.ex_ctrl_o (ex_ctrl_o),
		.rf1_req_o (rf1_req_o),
		.rf2_req_o (rf2_req_o),
		.imm_o     (imm)
	);

	//////////////////////////////
	// operand muxes
	//////////////////////////////
	// rs side
	operand_select u_op1 (
		.req_i     (rf1_req_o),
		.rf_data_i (rf1_data_i),
		.imm_i     (imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op1_o)
	);

	// rt side, also gets imm for I-type
	operand_select u_op2 (
		.req_i     (rf2_req_o),
		.rf_data_i (rf2_data_i),
		.imm_i     (imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op2_o)
	);

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import id_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic [DATA_W-1:0] pc_i,
	input  logic [DATA_W-1:0] inst_i,
	output ex_ctrl_t          ex_ctrl_o,
	output rf_req_t           rf1_req_o,
	output rf_req_t           rf2_req_o,
	output logic [DATA_W-1:0] imm_o
);

	localparam ex_ctrl_t NOP_CTRL = '{
		alusel: SEL_NOP,
		aluop:  ALUOP_NOP,
		wreg:   1'b0,
		waddr:  '0
	};

	opcode_e               opcode;
	funct_e                funct;
	aluop_e                itype_op;
	aluop_e                rtype_op;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [4:0]            shamt;
	logic [DATA_W-1:0]     imm_zext;
	logic [DATA_W-1:0]     imm_sext;
	logic [DATA_W-1:0]     shamt_zext;

	ex_ctrl_t              ex_ctrl_d;
	logic                  rf1_rd_d;
	logic                  rf2_rd_d;
	logic [DATA_W-1:0]     imm_d;

	function automatic ex_ctrl_t make_ctrl(
		input alusel_e               sel,
		input aluop_e                op,
		input logic                  we,
		input logic [REG_ADDR_W-1:0] addr
	);
		ex_ctrl_t c;
		c.alusel = sel;
		c.aluop  = op;
		c.wreg   = we;
		c.waddr  = addr;
		return c;
	endfunction

	//////////////////////////////
	// field split
	//////////////////////////////
	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct  = funct_e'(inst_i[5:0]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];

	// aluop is the raw code with two zero bits on top
	assign itype_op = aluop_e'({2'b00, inst_i[31:26]});
	assign rtype_op = aluop_e'({2'b00, inst_i[5:0]});

	assign imm_zext   = {{(DATA_W-16){1'b0}}, inst_i[15:0]};
	assign imm_sext   = {{(DATA_W-16){inst_i[15]}}, inst_i[15:0]};
	assign shamt_zext = {{(DATA_W-5){1'b0}}, shamt};

	//////////////////////////////
	// decode
	//////////////////////////////
	always_comb begin
		ex_ctrl_d = NOP_CTRL;
		rf1_rd_d  = 1'b0;
		rf2_rd_d  = 1'b0;
		imm_d     = '0;

		case (opcode)
			// logic immediates
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				ex_ctrl_d = make_ctrl(SEL_LOGIC, itype_op, 1'b1, rt);
				rf1_rd_d  = 1'b1;
				imm_d     = imm_zext;
			end
			// arithmetic immediates are sign-extended
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ex_ctrl_d = make_ctrl(SEL_ARITH, itype_op, 1'b1, rt);
				rf1_rd_d  = 1'b1;
				imm_d     = imm_sext;
			end
			// prefetch hint, nothing to execute
			OP_PREF: begin
				ex_ctrl_d.aluop = ALUOP_PREF;
			end
			OP_SPECIAL: begin
				case (funct)
					FN_AND, FN_OR, FN_XOR, FN_NOR: begin
						ex_ctrl_d = make_ctrl(SEL_LOGIC, rtype_op, 1'b1, rd);
						rf1_rd_d  = 1'b1;
						rf2_rd_d  = 1'b1;
					end
					// constant shift amount rides in imm
					FN_SLL, FN_SRL, FN_SRA: begin
						ex_ctrl_d = make_ctrl(SEL_SHIFT, rtype_op, 1'b1, rd);
						rf2_rd_d  = 1'b1;
						imm_d     = shamt_zext;
					end
					FN_SLLV, FN_SRLV, FN_SRAV: begin
						ex_ctrl_d = make_ctrl(SEL_SHIFT, rtype_op, 1'b1, rd);
						rf1_rd_d  = 1'b1;
						rf2_rd_d  = 1'b1;
					end
					FN_MOVN, FN_MOVZ: begin
						ex_ctrl_d = make_ctrl(SEL_MOVE, rtype_op, 1'b1, rd);
						rf1_rd_d  = 1'b1;
						rf2_rd_d  = 1'b1;
					end
					// hi/lo reads need no register file port
					FN_MFHI, FN_MFLO: begin
						ex_ctrl_d = make_ctrl(SEL_MOVE, rtype_op, 1'b1, rd);
					end
					FN_MTHI, FN_MTLO: begin
						ex_ctrl_d = make_ctrl(SEL_MOVE, rtype_op, 1'b0, rd);
						rf1_rd_d  = 1'b1;
					end
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: begin
						ex_ctrl_d = make_ctrl(SEL_ARITH, rtype_op, 1'b1, rd);
						rf1_rd_d  = 1'b1;
						rf2_rd_d  = 1'b1;
					end
					// product goes to hi/lo
					FN_MULT, FN_MULTU: begin
						ex_ctrl_d = make_ctrl(SEL_ARITH, rtype_op, 1'b0, rd);
						rf1_rd_d  = 1'b1;
						rf2_rd_d  = 1'b1;
					end
					FN_SYNC: begin
						ex_ctrl_d = NOP_CTRL;
					end
					default: begin
						ex_ctrl_d = NOP_CTRL;
					end
				endcase
			end
			default: begin
				ex_ctrl_d = NOP_CTRL;
			end
		endcase
	end

	//////////////////////////////
	// decode register
	//////////////////////////////
	// zero pc stalls the stage
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ex_ctrl_o      <= NOP_CTRL;
			rf1_req_o.rd   <= 1'b0;
			rf1_req_o.addr <= '0;
			rf2_req_o.rd   <= 1'b0;
			rf2_req_o.addr <= '0;
			imm_o          <= '0;
		end else if (pc_i != '0) begin
			ex_ctrl_o      <= ex_ctrl_d;
			rf1_req_o.rd   <= rf1_rd_d;
			rf1_req_o.addr <= rs;
			rf2_req_o.rd   <= rf2_rd_d;
			rf2_req_o.addr <= rt;
			imm_o          <= imm_d;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	// anything that writes back has a real ALU class
	a_wreg_class: assert property (
		@(posedge clk) disable iff (!reset_n)
		ex_ctrl_o.wreg |-> ex_ctrl_o.alusel != SEL_NOP
	) else $error("instr_decoder: wreg set with SEL_NOP");

	// no-ops never claim a register port
	a_nop_no_read: assert property (
		@(posedge clk) disable iff (!reset_n)
		ex_ctrl_o.alusel == SEL_NOP |-> !rf1_req_o.rd && !rf2_req_o.rd
	) else $error("instr_decoder: read flag set on a no-op");

endmodule

// File: design/operand_select.sv
`timescale 1ns/1ps

module operand_select
	import id_pkg::*;
(
	input  rf_req_t           req_i,
	input  logic [DATA_W-1:0] rf_data_i,
	input  logic [DATA_W-1:0] imm_i,
	input  fwd_t              ex_fwd_i,
	input  fwd_t              mem_fwd_i,
	output logic [DATA_W-1:0] operand_o
);

	logic ex_hit;
	logic mem_hit;

	//////////////////////////////
	// bypass match
	//////////////////////////////
	// a strobe only counts with its write enable
	assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == req_i.addr);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == req_i.addr);

	//////////////////////////////
	// operand mux
	//////////////////////////////
	// youngest result first
	always_comb begin
		if (!req_i.rd) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	// execute result must win over memory and regfile
	always_comb begin
		if (req_i.rd && ex_fwd_i.we && (ex_fwd_i.waddr == req_i.addr)) begin
			a_ex_priority: assert final (operand_o == ex_fwd_i.wdata)
				else $error("operand_select: operand %h, ex data %h",
					operand_o, ex_fwd_i.wdata);
		end
	end

endmodule

// File: verification/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

	// expected registered decode for one instruction
	typedef struct packed {
		ex_ctrl_t          ctrl;
		rf_req_t           rf1;
		rf_req_t           rf2;
		logic [DATA_W-1:0] imm;
	} decode_exp_t;

	// one row of the SPECIAL table
	typedef struct packed {
		alusel_e sel;
		logic    wr;
		logic    r1;
		logic    r2;
		logic    sa;
	} rtype_row_t;

	function automatic logic [DATA_W-1:0] itype_word(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic logic [DATA_W-1:0] rtype_word(input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic rtype_row_t rtype_row(input logic [5:0] fn);
		rtype_row_t row;
		case (fn)
			FN_AND, FN_OR, FN_XOR, FN_NOR:    row = '{SEL_LOGIC, 1'b1, 1'b1, 1'b1, 1'b0};
			FN_SLL, FN_SRL, FN_SRA:           row = '{SEL_SHIFT, 1'b1, 1'b0, 1'b1, 1'b1};
			FN_SLLV, FN_SRLV, FN_SRAV:        row = '{SEL_SHIFT, 1'b1, 1'b1, 1'b1, 1'b0};
			FN_MOVN, FN_MOVZ:                 row = '{SEL_MOVE, 1'b1, 1'b1, 1'b1, 1'b0};
			FN_MFHI, FN_MFLO:                 row = '{SEL_MOVE, 1'b1, 1'b0, 1'b0, 1'b0};
			FN_MTHI, FN_MTLO:                 row = '{SEL_MOVE, 1'b0, 1'b1, 1'b0, 1'b0};
			FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: row = '{SEL_ARITH, 1'b1, 1'b1, 1'b1, 1'b0};
			FN_SLT, FN_SLTU:                  row = '{SEL_ARITH, 1'b1, 1'b1, 1'b1, 1'b0};
			FN_MULT, FN_MULTU:                row = '{SEL_ARITH, 1'b0, 1'b1, 1'b1, 1'b0};
			// sync and unknown codes
			default:                          row = '{SEL_NOP, 1'b0, 1'b0, 1'b0, 1'b0};
		endcase
		return row;
	endfunction

	function automatic decode_exp_t expected_decode(input logic [DATA_W-1:0] word);
		decode_exp_t e;
		rtype_row_t  row;
		logic        sext;
		e = '0;
		e.rf1.addr = word[25:21];
		e.rf2.addr = word[20:16];
		case (word[31:26])
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				// arithmetic opcodes sit below andi
				sext = word[31:26] < OP_ANDI;
				e.ctrl.alusel = sext ? SEL_ARITH : SEL_LOGIC;
				e.ctrl.aluop  = aluop_e'({2'b00, word[31:26]});
				e.ctrl.wreg   = 1'b1;
				e.ctrl.waddr  = word[20:16];
				e.rf1.rd      = 1'b1;
				e.imm = sext ? {{16{word[15]}}, word[15:0]} : {16'h0000, word[15:0]};
			end
			OP_PREF: e.ctrl.aluop = ALUOP_PREF;
			OP_SPECIAL: begin
				row = rtype_row(word[5:0]);
				if (row.sel != SEL_NOP) begin
					e.ctrl.alusel = row.sel;
					e.ctrl.aluop  = aluop_e'({2'b00, word[5:0]});
					e.ctrl.wreg   = row.wr;
					e.ctrl.waddr  = word[15:11];
					e.rf1.rd      = row.r1;
					e.rf2.rd      = row.r2;
					if (row.sa)
						e.imm = {27'h0, word[10:6]};
				end
			end
			default: ;
		endcase
		return e;
	endfunction

	// youngest matching result wins, else regfile, imm when not read
	function automatic logic [DATA_W-1:0] expected_operand(input rf_req_t req,
		input logic [DATA_W-1:0] rf, input logic [DATA_W-1:0] imm, input fwd_t ex, input fwd_t mem);
		if (!req.rd)
			return imm;
		if (ex.we && ex.waddr == req.addr)
			return ex.wdata;
		if (mem.we && mem.waddr == req.addr)
			return mem.wdata;
		return rf;
	endfunction

`endif

// File: verification/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb
	import id_pkg::*;
();

	`include "id_ref_model.svh"

	localparam int NUM_TESTS = 5;

	logic              clk;
	logic              reset_n;
	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] inst;
	logic [DATA_W-1:0] rf1_data;
	logic [DATA_W-1:0] rf2_data;
	fwd_t              ex_fwd;
	fwd_t              mem_fwd;
	ex_ctrl_t          ex_ctrl;
	rf_req_t           rf1_req;
	rf_req_t           rf2_req;
	logic [DATA_W-1:0] op1;
	logic [DATA_W-1:0] op2;

	decode_exp_t       exp_q;
	logic [DATA_W-1:0] next_pc;
	integer            seed;
	int                errors;
	int                passed;
	int                failed;

	id_stage DUT (
		.clk        (clk),
		.reset_n    (reset_n),
		.pc_i       (pc),
		.inst_i     (inst),
		.rf1_data_i (rf1_data),
		.rf2_data_i (rf2_data),
		.rf1_req_o  (rf1_req),
		.rf2_req_o  (rf2_req),
		.ex_fwd_i   (ex_fwd),
		.mem_fwd_i  (mem_fwd),
		.ex_ctrl_o  (ex_ctrl),
		.op1_o      (op1),
		.op2_o      (op2)
	);

	always #5 clk = ~clk;

	// expected decode, one cycle behind inst, held while pc is zero
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			exp_q <= '0;
		else if (pc != '0)
			exp_q <= expected_decode(inst);
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_ctrl: assert property (@(posedge clk) disable iff (!reset_n) ex_ctrl == exp_q.ctrl)
		else begin
			errors++;
			$display("** Error: ex_ctrl_o expected %h, got %h", $sampled(exp_q.ctrl),
				$sampled(ex_ctrl));
		end

	a_rf1: assert property (@(posedge clk) disable iff (!reset_n) rf1_req == exp_q.rf1)
		else begin
			errors++;
			$display("** Error: rf1_req_o expected %h, got %h", $sampled(exp_q.rf1),
				$sampled(rf1_req));
		end

	a_rf2: assert property (@(posedge clk) disable iff (!reset_n) rf2_req == exp_q.rf2)
		else begin
			errors++;
			$display("** Error: rf2_req_o expected %h, got %h", $sampled(exp_q.rf2),
				$sampled(rf2_req));
		end

	a_op1: assert property (@(posedge clk) disable iff (!reset_n)
		op1 == expected_operand(exp_q.rf1, rf1_data, exp_q.imm, ex_fwd, mem_fwd))
		else begin
			errors++;
			$display("** Error: op1_o expected %h, got %h", expected_operand($sampled(exp_q.rf1),
				$sampled(rf1_data), $sampled(exp_q.imm), $sampled(ex_fwd), $sampled(mem_fwd)),
				$sampled(op1));
		end

	a_op2: assert property (@(posedge clk) disable iff (!reset_n)
		op2 == expected_operand(exp_q.rf2, rf2_data, exp_q.imm, ex_fwd, mem_fwd))
		else begin
			errors++;
			$display("** Error: op2_o expected %h, got %h", expected_operand($sampled(exp_q.rf2),
				$sampled(rf2_data), $sampled(exp_q.imm), $sampled(ex_fwd), $sampled(mem_fwd)),
				$sampled(op2));
		end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////
	function automatic logic [4:0] random_reg();
		logic [31:0] r;
		r = $random(seed);
		return r[4:0];
	endfunction

	function automatic logic [15:0] random_half();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic logic [DATA_W-1:0] random_word();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic fwd_t quiet_fwd();
		return fwd_t'{1'b0, random_reg(), random_word()};
	endfunction

	// instruction on one edge, bypass and regfile data on the next
	task automatic present(input logic [DATA_W-1:0] word, input fwd_t ex, input fwd_t mem);
		@(posedge clk);
		pc <= next_pc;
		inst <= word;
		next_pc = next_pc + 4;
		@(posedge clk);
		ex_fwd   <= ex;
		mem_fwd  <= mem;
		rf1_data <= random_word();
		rf2_data <= random_word();
	endtask

	task automatic end_test(input string name, input int errs_before);
		repeat (2) @(posedge clk);
		if (errors == errs_before) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: FAIL with %0d errors", name, errors - errs_before);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	initial begin
		opcode_e           op;
		funct_e            fn;
		int                mark;
		logic [4:0]        rs;
		logic [4:0]        rt;
		logic [DATA_W-1:0] word;
		seed     = 35;
		clk      = 1'b0;
		reset_n  = 1'b0;
		pc       = '0;
		inst     = '0;
		rf1_data = '0;
		rf2_data = '0;
		ex_fwd   = '0;
		mem_fwd  = '0;
		next_pc  = 4;
		errors   = 0;
		passed   = 0;
		failed   = 0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		// pc still zero, reset word must stay
		mark = errors;
		repeat (3) @(posedge clk);
		end_test("reset", mark);

		mark = errors;
		op = op.first();
		for (int i = 0; i < op.num(); i++) begin
			present(itype_word(op, random_reg(), random_reg(), random_half()),
				quiet_fwd(), quiet_fwd());
			op = op.next();
		end
		end_test("itype", mark);

		mark = errors;
		fn = fn.first();
		for (int i = 0; i < fn.num(); i++) begin
			present(rtype_word(random_reg(), random_reg(), random_reg(), random_reg(), fn),
				quiet_fwd(), quiet_fwd());
			fn = fn.next();
		end
		end_test("rtype", mark);

		// both match, memory only, we clear, no match
		mark = errors;
		repeat (4) begin
			rs = random_reg();
			rt = random_reg();
			word = rtype_word(rs, rt, random_reg(), 5'd0, FN_ADD);
			present(word, fwd_t'{1'b1, rs, random_word()}, fwd_t'{1'b1, rs, random_word()});
			present(word, fwd_t'{1'b1, ~rs, random_word()}, fwd_t'{1'b1, rs, random_word()});
			present(word, fwd_t'{1'b0, rs, random_word()}, fwd_t'{1'b0, rs, random_word()});
			present(word, fwd_t'{1'b1, ~rs, random_word()}, fwd_t'{1'b1, ~rs, random_word()});
			present(word, fwd_t'{1'b1, rt, random_word()}, fwd_t'{1'b1, rt, random_word()});
		end
		end_test("forwarding", mark);

		mark = errors;
		present(itype_word(OP_ORI, random_reg(), random_reg(), random_half()),
			quiet_fwd(), quiet_fwd());
		@(posedge clk);
		pc <= '0;
		repeat (3) begin
			@(posedge clk);
			inst <= random_word();
		end
		present(itype_word(6'h23, random_reg(), random_reg(), random_half()),
			quiet_fwd(), quiet_fwd());
		present(itype_word(6'h1C, random_reg(), random_reg(), random_half()),
			quiet_fwd(), quiet_fwd());
		present(rtype_word(random_reg(), random_reg(), random_reg(), 5'd0, 6'h01),
			quiet_fwd(), quiet_fwd());
		present(rtype_word(random_reg(), random_reg(), random_reg(), 5'd0, 6'h3F),
			quiet_fwd(), quiet_fwd());
		end_test("hold_unknown", mark);

		$display("tests passed %0d, failed %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog, 200 cycles per test
	initial begin
		#(NUM_TESTS * 200 * 10);
		$display("timeout: tests did not finish within the watchdog limit");
		$display("Something failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verification
design/id_pkg.sv
design/instr_decoder.sv
design/operand_select.sv
design/id_stage.sv
verification/id_stage_tb.sv
